// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log for failures

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module tb_top -f soc_bus_top.f -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_top_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Done: errors found" "$log"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

// ==== soc_bus_top.f ====
+incdir+src
src/soc_pkg.sv
src/bus_decoder.sv
src/sram_bank.sv
src/io_regs.sv
src/uart_fifo.sv
src/soc_bus_top.sv
verif/tb_clock.sv
verif/tb_top.sv

// ==== src/bus_decoder.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module bus_decoder import soc_pkg::*; (
    input logic clk,
    input logic rst,
    input logic mem_valid,
    input addr_t mem_addr,
    output logic mem_ready,
    output data_t mem_rdata,
    output logic ram_req,
    output logic port_req,
    output logic ctrl_req,
    output logic uart_req,
    input data_t ram_rdata,
    input data_t led_rdata,
    input data_t ctrl_rdata,
    input data_t uart_rdata,
    input logic uart_ack
);

    region_t region;
    logic new_req;
    logic other_req;
    logic ram_q;
    data_t rdata_next;
    data_t rdata_q;

    assign region = mem_addr[31:28];

    // A request is only live while no completion is pending
    assign new_req = mem_valid && !mem_ready;

    assign ram_req = new_req && (region == `SOC_REGION_RAM);
    assign port_req = new_req && (region == `SOC_REGION_PORT);
    assign ctrl_req = new_req && (region == `SOC_REGION_UART_CTRL);
    assign uart_req = new_req && (region == `SOC_REGION_UART_DATA);
    assign other_req = new_req && !ram_req && !port_req && !ctrl_req && !uart_req;

    always_comb begin
        case (region)
            `SOC_REGION_PORT: rdata_next = led_rdata;
            `SOC_REGION_UART_CTRL: rdata_next = ctrl_rdata;
            `SOC_REGION_UART_DATA: rdata_next = uart_rdata;
            default: rdata_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            ram_q <= 1'b0;
        end else begin
            mem_ready <= ram_req || port_req || ctrl_req || other_req || uart_ack;
            ram_q <= ram_req;
        end
    end

    // Last capture before ready rises is the one the master sees
    always_ff @(posedge clk) begin
        if (new_req)
            rdata_q <= rdata_next;
    end

    // RAM word is already registered inside the bank
    assign mem_rdata = ram_q ? ram_rdata : rdata_q;

endmodule

// ==== src/io_regs.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module io_regs import soc_pkg::*; (
    input logic clk,
    input logic rst,
    input logic port_req,
    input logic ctrl_req,
    input data_t wdata,
    input strb_t wstrb,
    output led_t led,
    output data_t led_rdata,
    output data_t ctrl_rdata,
    output div_t uart_div,
    input logic tx_full,
    input logic rx_empty
);

    logic led_write;
    logic div_write;

    assign led_write = port_req && wstrb[0];

    // The divisor is a halfword, so both low lanes must be written
    assign div_write = ctrl_req && (wstrb[1:0] == 2'b11);

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= '0;
            uart_div <= `SOC_UART_DIV_RESET;
        end else begin
            if (led_write)
                led <= wdata[1:0];
            if (div_write)
                uart_div <= wdata[15:0];
        end
    end

    assign led_rdata = {30'h0, led};

    // Status word: divisor on top, FIFO flags in the two low bits
    assign ctrl_rdata = {uart_div, 14'h0, rx_empty, tx_full};

endmodule

// ==== src/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top import soc_pkg::*; (
    input logic clk,
    input logic rst,
    input logic mem_valid,
    input addr_t mem_addr,
    input data_t mem_wdata,
    input strb_t mem_wstrb,
    output logic mem_ready,
    output data_t mem_rdata,
    output led_t led,
    output logic tx,
    input logic rx
);

    logic ram_req;
    logic port_req;
    logic ctrl_req;
    logic uart_req;
    logic uart_ack;
    data_t ram_rdata;
    data_t led_rdata;
    data_t ctrl_rdata;
    data_t uart_rdata;
    div_t uart_div;
    logic tx_full;
    logic rx_empty;

    bus_decoder decoder0 (
        .clk(clk), .rst(rst),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .ram_req(ram_req), .port_req(port_req), .ctrl_req(ctrl_req), .uart_req(uart_req),
        .ram_rdata(ram_rdata), .led_rdata(led_rdata), .ctrl_rdata(ctrl_rdata),
        .uart_rdata(uart_rdata), .uart_ack(uart_ack)
    );

    sram_bank ram0 (
        .clk(clk), .ram_req(ram_req),
        .addr(mem_addr), .wdata(mem_wdata), .wstrb(mem_wstrb),
        .ram_rdata(ram_rdata)
    );

    io_regs regs0 (
        .clk(clk), .rst(rst),
        .port_req(port_req), .ctrl_req(ctrl_req),
        .wdata(mem_wdata), .wstrb(mem_wstrb),
        .led(led), .led_rdata(led_rdata), .ctrl_rdata(ctrl_rdata),
        .uart_div(uart_div), .tx_full(tx_full), .rx_empty(rx_empty)
    );

    uart_fifo uart0 (
        .clk(clk), .rst(rst),
        .uart_req(uart_req), .wstrb(mem_wstrb), .wdata(mem_wdata),
        .uart_rdata(uart_rdata), .uart_ack(uart_ack), .uart_div(uart_div),
        .tx_full(tx_full), .rx_empty(rx_empty), .tx(tx), .rx(rx)
    );

endmodule

// ==== src/soc_pkg.sv ====
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0] strb_t;
    typedef logic [7:0] byte_t;

    // Top four address bits pick the slave
    typedef logic [3:0] region_t;

    // One UART bit lasts this many clock cycles
    typedef logic [15:0] div_t;

    typedef logic [1:0] led_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_t;

endpackage

// ==== src/soc_settings.svh ====
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// RAM word-address width, 1024 words
`define SOC_RAM_BITS 10

// Each UART FIFO holds 2**SOC_FIFO_BITS bytes
`define SOC_FIFO_BITS 3

`define SOC_UART_DIV_RESET 16'd8

// Region codes taken from address bits 31:28
`define SOC_REGION_RAM 4'd2
`define SOC_REGION_PORT 4'd3
`define SOC_REGION_UART_DATA 4'd4
`define SOC_REGION_UART_CTRL 4'd5

`endif

// ==== src/sram_bank.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module sram_bank import soc_pkg::*; (
    input logic clk,
    input logic ram_req,
    input addr_t addr,
    input data_t wdata,
    input strb_t wstrb,
    output data_t ram_rdata
);

    localparam int WORDS = 1 << `SOC_RAM_BITS;

    byte_t lane0 [WORDS];
    byte_t lane1 [WORDS];
    byte_t lane2 [WORDS];
    byte_t lane3 [WORDS];
    logic [`SOC_RAM_BITS-1:0] word_idx;

    // Bits 1:0 are the byte offset within a word
    assign word_idx = addr[`SOC_RAM_BITS+1:2];

    always_ff @(posedge clk) begin
        if (ram_req) begin
            if (wstrb[0])
                lane0[word_idx] <= wdata[7:0];
            if (wstrb[1])
                lane1[word_idx] <= wdata[15:8];
            if (wstrb[2])
                lane2[word_idx] <= wdata[23:16];
            if (wstrb[3])
                lane3[word_idx] <= wdata[31:24];
            // Old contents come back even on a write
            ram_rdata <= {lane3[word_idx], lane2[word_idx], lane1[word_idx], lane0[word_idx]};
        end
    end

endmodule

// ==== src/uart_fifo.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module uart_fifo import soc_pkg::*; (
    input logic clk,
    input logic rst,
    input logic uart_req,
    input strb_t wstrb,
    input data_t wdata,
    output data_t uart_rdata,
    output logic uart_ack,
    input div_t uart_div,
    output logic tx_full,
    output logic rx_empty,
    output logic tx,
    input logic rx
);

    localparam int B = `SOC_FIFO_BITS;
    localparam int DEPTH = 1 << B;

    byte_t tx_mem [DEPTH];
    byte_t rx_mem [DEPTH];
    logic [B:0] tx_wr, tx_rd, rx_wr, rx_rd;
    logic tx_empty, rx_full;
    logic bus_write, tx_push, tx_pop, rx_push, rx_pop;
    uart_tx_state_t tx_state;
    uart_rx_state_t rx_state;
    div_t tx_cnt, rx_cnt;
    logic [2:0] tx_bit, rx_bit;
    byte_t tx_shift, rx_shift;
    logic rx_meta, rx_sync;

    // Pointers carry one extra bit to tell full from empty
    assign tx_empty = (tx_wr == tx_rd);
    assign tx_full = (tx_wr[B] != tx_rd[B]) && (tx_wr[B-1:0] == tx_rd[B-1:0]);
    assign rx_empty = (rx_wr == rx_rd);
    assign rx_full = (rx_wr[B] != rx_rd[B]) && (rx_wr[B-1:0] == rx_rd[B-1:0]);

    assign bus_write = |wstrb;
    assign tx_push = uart_req && bus_write && !tx_full;
    assign rx_pop = uart_req && !bus_write && !rx_empty;
    assign uart_ack = tx_push || rx_pop;
    assign uart_rdata = {24'h0, rx_mem[rx_rd[B-1:0]]};

    assign tx_pop = (tx_state == TX_IDLE) && !tx_empty;
    // A byte arriving with the FIFO full is lost
    assign rx_push = (rx_state == RX_STOP) && (rx_cnt == '0) && rx_sync && !rx_full;

    always_ff @(posedge clk) begin
        if (tx_push)
            tx_mem[tx_wr[B-1:0]] <= wdata[7:0];
        if (rx_push)
            rx_mem[rx_wr[B-1:0]] <= rx_shift;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_wr <= '0;
            tx_rd <= '0;
            rx_wr <= '0;
            rx_rd <= '0;
        end else begin
            tx_wr <= tx_wr + {{B{1'b0}}, tx_push};
            tx_rd <= tx_rd + {{B{1'b0}}, tx_pop};
            rx_wr <= rx_wr + {{B{1'b0}}, rx_push};
            rx_rd <= rx_rd + {{B{1'b0}}, rx_pop};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= TX_IDLE;
            tx <= 1'b1;
            tx_cnt <= '0;
            tx_bit <= '0;
        end else if (tx_state == TX_IDLE) begin
            if (tx_pop) begin
                tx_shift <= tx_mem[tx_rd[B-1:0]];
                tx <= 1'b0;
                tx_cnt <= uart_div - 16'd1;
                tx_state <= TX_START;
            end
        end else if (tx_cnt != '0) begin
            tx_cnt <= tx_cnt - 16'd1;
        end else begin
            tx_cnt <= uart_div - 16'd1;
            case (tx_state)
                TX_START: begin
                    tx <= tx_shift[0];
                    tx_bit <= '0;
                    tx_state <= TX_DATA;
                end
                TX_DATA: begin
                    if (tx_bit == 3'd7) begin
                        tx <= 1'b1;
                        tx_state <= TX_STOP;
                    end else begin
                        tx <= tx_shift[1];
                        tx_shift <= tx_shift >> 1;
                        tx_bit <= tx_bit + 3'd1;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_state <= RX_IDLE;
            rx_cnt <= '0;
            rx_bit <= '0;
        end else if (rx_state == RX_IDLE) begin
            // Half a bit period lands the first sample mid start bit
            if (!rx_sync) begin
                rx_cnt <= (uart_div >> 1) - 16'd1;
                rx_state <= RX_START;
            end
        end else if (rx_cnt != '0) begin
            rx_cnt <= rx_cnt - 16'd1;
        end else begin
            rx_cnt <= uart_div - 16'd1;
            case (rx_state)
                RX_START: begin
                    rx_bit <= '0;
                    rx_state <= rx_sync ? RX_IDLE : RX_DATA;
                end
                RX_DATA: begin
                    rx_shift <= {rx_sync, rx_shift[7:1]};
                    rx_bit <= rx_bit + 3'd1;
                    if (rx_bit == 3'd7)
                        rx_state <= RX_STOP;
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

endmodule

// ==== verif/bus_tests.txt ====
# op name addr wdata strb expected, all numbers in hex
# S and U use fixed register addresses, W and L ignore unused columns
S status_reset 0 0 0 00080002
W ram_w0 20000000 11223344 f 0
W ram_w1 20000004 a5a5a5a5 f 0
W ram_w2 20000ffc deadbeef f 0
R ram_r0 20000000 0 0 11223344
R ram_r1 20000004 0 0 a5a5a5a5
R ram_r2 20000ffc 0 0 deadbeef
W ram_lane0 20000004 000000ff 1 0
W ram_lanes23 20000004 12340000 c 0
R ram_merge1 20000004 0 0 1234a5ff
W ram_lane2 20000000 00990000 4 0
R ram_merge0 20000000 0 0 11993344
W led_w3 30000000 00000007 1 0
L led_chk3 0 0 0 3
R led_r3 30000000 0 0 00000003
W led_w1 30000000 fffffffd 1 0
L led_chk1 0 0 0 1
W led_nolane0 30000000 00000002 2 0
R led_keep 30000000 0 0 00000001
R unmapped_r7 70000000 0 0 00000000
W unmapped_w7 70000000 ffffffff f 0
W unmapped_w0 00000004 ffffffff f 0
R unmapped_r0 00000004 0 0 00000000
R ram_untouched 20000004 0 0 1234a5ff
L led_untouched 0 0 0 1
W div16 50000000 00000010 3 0
S status_div16 0 0 0 00100002
W tx_a 40000000 12345641 1 0
W tx_b 40000000 0000005a 1 0
W tx_c 40000000 000000c3 1 0
U rx_a 0 0 0 41
U rx_b 0 0 0 5a
U rx_c 0 0 0 c3
S status_idle 0 0 0 00100002
# Nine bytes fill the transmit FIFO and the tenth stalls until a slot frees
W bp_0 40000000 00000010 1 0
W bp_1 40000000 00000021 1 0
W bp_2 40000000 00000032 1 0
W bp_3 40000000 00000043 1 0
W bp_4 40000000 00000054 1 0
W bp_5 40000000 00000065 1 0
W bp_6 40000000 00000076 1 0
W bp_7 40000000 00000087 1 0
W bp_8 40000000 00000098 1 0
S status_full 0 0 0 00100003
W bp_9 40000000 000000a9 1 0
U rb_0 0 0 0 10
U rb_1 0 0 0 21
U rb_2 0 0 0 32
U rb_3 0 0 0 43
U rb_4 0 0 0 54
U rb_5 0 0 0 65
U rb_6 0 0 0 76
U rb_7 0 0 0 87
U rb_8 0 0 0 98
U rb_9 0 0 0 a9
S status_drained 0 0 0 00100002

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_top import soc_pkg::*; ();

    logic clk;
    logic rst;
    logic mem_valid;
    addr_t mem_addr;
    data_t mem_wdata;
    strb_t mem_wstrb;
    logic mem_ready;
    data_t mem_rdata;
    led_t led;
    logic serial_line;
    int cycles;
    int limit;

    tb_clock clock0 (.clk(clk));

    // The UART transmitter feeds its own receiver
    soc_bus_top dut0 (
        .clk(clk), .rst(rst),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .led(led), .tx(serial_line), .rx(serial_line)
    );

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_led(input string name, input led_t expected, input led_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // Called 2 ns after a rising edge and returns at the same phase
    task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t strb,
            output data_t rdata);
        int waits;
        waits = 0;
        mem_valid = 1'b1;
        mem_addr = addr;
        mem_wdata = wdata;
        mem_wstrb = strb;
        @(posedge clk);
        #2;
        while (!mem_ready) begin
            waits = waits + 1;
            @(posedge clk);
            #2;
        end
        // Only the UART data register may hold the master off
        if (waits != 0 && addr[31:28] != `SOC_REGION_UART_DATA) begin
            $display("bus access to %h was held off for %0d extra cycles", addr, waits);
            abort_run();
        end
        rdata = mem_rdata;
        // The access completes on the next edge
        @(posedge clk);
        #2;
        mem_valid = 1'b0;
        mem_wstrb = '0;
        if (mem_ready !== 1'b0) begin
            $display("bus ready stayed high after the access to %h completed", addr);
            abort_run();
        end
    endtask

    // Lines whose first token is # are skipped
    task automatic read_test(input int fd, output bit found, output string op,
            output string name, output addr_t addr, output data_t wdata,
            output strb_t strb, output data_t expected);
        int n;
        int c;
        found = 1'b0;
        n = $fscanf(fd, " %s", op);
        while (n == 1 && op == "#") begin
            c = 0;
            while (c != 10 && c != -1)
                c = $fgetc(fd);
            n = $fscanf(fd, " %s", op);
        end
        if (n == 1) begin
            n = $fscanf(fd, " %s %h %h %h %h", name, addr, wdata, strb, expected);
            if (n != 5) begin
                $display("test file has a malformed line starting with %s", op);
                abort_run();
            end
            found = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the bus stopped responding", cycles);
            abort_run();
        end
    end

    initial begin
        int fd;
        int count;
        int done;
        bit found;
        string op;
        string name;
        addr_t addr;
        data_t wdata;
        strb_t strb;
        data_t expected;
        data_t rdata;
        div_t div_max;

        rst = 1'b1;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        cycles = 0;
        limit = 0;

        // First pass sizes the timeout from the test count and the slowest baud
        fd = $fopen("verif/bus_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/bus_tests.txt");
            abort_run();
        end
        count = 0;
        div_max = `SOC_UART_DIV_RESET;
        read_test(fd, found, op, name, addr, wdata, strb, expected);
        while (found) begin
            count = count + 1;
            if (op == "W" && addr[31:28] == `SOC_REGION_UART_CTRL && strb[1:0] == 2'b11
                    && wdata[15:0] > div_max)
                div_max = wdata[15:0];
            read_test(fd, found, op, name, addr, wdata, strb, expected);
        end
        $fclose(fd);
        limit = count * 12 * int'(div_max) + 16;

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        fd = $fopen("verif/bus_tests.txt", "r");
        done = 0;
        read_test(fd, found, op, name, addr, wdata, strb, expected);
        while (found) begin
            if (op == "W") begin
                bus_access(addr, wdata, strb, rdata);
            end else if (op == "R") begin
                bus_access(addr, '0, '0, rdata);
                check_data(name, expected, rdata);
            end else if (op == "L") begin
                check_led(name, expected[1:0], led);
            end else if (op == "S") begin
                bus_access({`SOC_REGION_UART_CTRL, 28'h0}, '0, '0, rdata);
                check_data(name, expected, rdata);
            end else if (op == "U") begin
                bus_access({`SOC_REGION_UART_DATA, 28'h0}, '0, '0, rdata);
                check_byte(name, expected[7:0], rdata[7:0]);
            end else begin
                $display("test %s has an unknown operation %s", name, op);
                abort_run();
            end
            done = done + 1;
            read_test(fd, found, op, name, addr, wdata, strb, expected);
        end
        $fclose(fd);

        if (done == 0) begin
            $display("no tests were found in verif/bus_tests.txt");
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule
